// File: Makefile
# Verilator build and run of the dual APB timer testbench.

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f --top-module timer_tb -o timer_sim
	./obj_dir/timer_sim | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir

// File: sim/tb_clock.sv
//--------------------------------------------------------------------------
// Clock and reset source of the timer testbench.
//--------------------------------------------------------------------------
module tb_clock (
  output logic o_pclk,
  output logic o_presetn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    o_pclk    = 1'b0;
    o_presetn = 1'b0;
    repeat (16) @(posedge o_pclk);
    #1;
    o_presetn = 1'b1;  // released just after the 16th rising edge.
  end

  always #5 o_pclk = ~o_pclk;

endmodule

// File: sim/timer_tb.sv
//--------------------------------------------------------------------------
// Testbench of the dual APB timer: stimulus table, APB tasks, LFSR loads,
// compare tasks and a watchdog.
//--------------------------------------------------------------------------
module timer_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [2:0] {OP_WR, OP_WR_OFF, OP_RD, OP_RD_GT, OP_WAIT, OP_IDLE, OP_STROBE,
                            OP_TRIG} op_e;

  typedef struct packed {
    op_e                      op;
    timer_reg_pkg::apb_addr_t addr;   // byte address, or the channel of a trigger count.
    timer_reg_pkg::apb_data_t data;   // write data, o_intr mask or strobes {off, on}.
    timer_reg_pkg::apb_data_t expv;
    int                       bound;  // wait limit or window in cycles.
  } row_t;

  logic                     pclk;
  logic                     presetn;
  logic                     i_psel;
  logic                     i_penable;
  logic                     i_pwrite;
  timer_reg_pkg::apb_addr_t i_paddr;
  timer_reg_pkg::apb_data_t i_pwdata;
  timer_cfg_pkg::ch_mask_t  i_etb_trig_en_on;
  timer_cfg_pkg::ch_mask_t  i_etb_trig_en_off;
  timer_reg_pkg::apb_data_t o_prdata;
  timer_cfg_pkg::ch_mask_t  o_intr;
  timer_cfg_pkg::ch_mask_t  o_etb_trig;
  row_t                     rows[$];
  logic [15:0]              lfsr_q = 16'd44;
  int                       errors = 0;
  int                       loads[5];
  int                       limit;

  tb_clock u_clock (.o_pclk(pclk), .o_presetn(presetn));
  timer_top UUT (.*);

  function automatic timer_reg_pkg::apb_addr_t byte_addr(input timer_reg_pkg::reg_idx_t idx);
    return {idx, 2'b00};
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  function automatic void add_row(input op_e op, input timer_reg_pkg::apb_addr_t addr,
                                  input int data, input int expv, input int bound);
    row_t r;
    r = '{op, addr, data, expv, bound};
    rows.push_back(r);
  endfunction

  task automatic compare_data(input string name, input timer_reg_pkg::apb_data_t expv,
                              input timer_reg_pkg::apb_data_t actual);
    if (actual !== expv)
    begin
      errors++;
      $display("FAIL %0t %s expected %h actual %h", $time, name, expv, actual);
    end
  endtask

  task automatic compare_mask(input string name, input timer_cfg_pkg::ch_mask_t expv,
                              input timer_cfg_pkg::ch_mask_t actual);
    if (actual !== expv)
    begin
      errors++;
      $display("FAIL %0t %s expected %b actual %b", $time, name, expv, actual);
    end
  endtask

  task automatic apb_write(input timer_reg_pkg::apb_addr_t addr,
                           input timer_reg_pkg::apb_data_t data, input timer_cfg_pkg::ch_mask_t off);
    @(posedge pclk);
    #1;
    i_psel   = 1'b1;
    i_pwrite = 1'b1;
    i_paddr  = addr;
    i_pwdata = data;
    @(posedge pclk);
    #1;
    i_penable         = 1'b1;
    i_etb_trig_en_off = off;  // lands on the same edge as the write.
    @(posedge pclk);
    #1;
    i_psel            = 1'b0;
    i_penable         = 1'b0;
    i_pwrite          = 1'b0;
    i_etb_trig_en_off = '0;
  endtask

  task automatic apb_read(input timer_reg_pkg::apb_addr_t addr,
                          output timer_reg_pkg::apb_data_t rdata);
    @(posedge pclk);
    #1;
    i_psel   = 1'b1;
    i_pwrite = 1'b0;
    i_paddr  = addr;
    @(posedge pclk);
    #1;
    i_penable = 1'b1;
    rdata     = o_prdata;  // registered at the setup edge.
    @(posedge pclk);
    #1;
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic read_check(input timer_reg_pkg::apb_addr_t addr,
                            input timer_reg_pkg::apb_data_t expv, input logic above);
    timer_reg_pkg::apb_data_t rdata;
    apb_read(addr, rdata);
    if (!above)
      compare_data($sformatf("o_prdata[%02h]", addr), expv, rdata);
    else if (rdata <= expv)
    begin
      errors++;
      $display("FAIL %0t o_prdata[%02h] expected above %h actual %h", $time, addr, expv, rdata);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge pclk);
    #1;
  endtask

  task automatic wait_intr(input timer_cfg_pkg::ch_mask_t mask,
                           input timer_cfg_pkg::ch_mask_t expv, input int bound);
    int n;
    n = 0;
    while (((o_intr & mask) !== expv) && (n < bound))
    begin
      @(posedge pclk);
      #1;
      n++;
    end
    if (bound == 0)
      compare_mask("o_intr", expv, o_intr & mask);
    else if ((o_intr & mask) !== expv)
    begin
      errors++;
      $display("the interrupt never arrived: o_intr was %b after %0d cycles", o_intr, bound);
    end
  endtask

  task automatic pulse_strobe(input timer_cfg_pkg::ch_mask_t on,
                              input timer_cfg_pkg::ch_mask_t off);
    @(posedge pclk);
    #1;
    i_etb_trig_en_on  = on;
    i_etb_trig_en_off = off;
    @(posedge pclk);
    #1;
    i_etb_trig_en_on  = '0;
    i_etb_trig_en_off = '0;
    wait_cycles(1);  // pending follows the enable one cycle later.
  endtask

  task automatic count_trig(input logic ch, input int window, input int expv);
    int n;
    n = 0;
    repeat (window)
    begin
      @(posedge pclk);
      #1;
      if (o_etb_trig[ch])
        n++;
    end
    if ((n < expv - 1) || (n > expv + 1))
    begin
      errors++;
      $display("FAIL %0t o_etb_trig[%0d] count expected %0d actual %0d", $time, ch, expv, n);
    end
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge pclk);
    $display("timeout after %0d cycles, the table never finished; errors: %0d", cycles, errors);
    $display("Test failed");
    $finish;
  endtask

  initial
  begin
    int ctl_user;
    int ctl_free;
    int ctl_mask;
    int ctl_bits;
    i_psel            = 1'b0;
    i_penable         = 1'b0;
    i_pwrite          = 1'b0;
    i_paddr           = '0;
    i_pwdata          = '0;
    i_etb_trig_en_on  = '0;
    i_etb_trig_en_off = '0;
    ctl_free = 1 << timer_reg_pkg::CTRL_EN;
    ctl_user = ctl_free | (1 << timer_reg_pkg::CTRL_MODE);
    ctl_mask = ctl_user | (1 << timer_reg_pkg::CTRL_MASK);
    ctl_bits = (1 << timer_reg_pkg::CTRL_W) - 1;
    foreach (loads[k])
      loads[k] = take_bits(5) + 4;

    add_row(OP_WR, byte_addr(timer_reg_pkg::T1LC), 32'h1234_5678, 0, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T1LC), 0, 32'h1234_5678, 0);
    add_row(OP_WR, byte_addr(timer_reg_pkg::T2CR), 32'hFFFF_FFFC, 0, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T2CR), 0, 32'hFFFF_FFFC & ctl_bits, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T1CV), 0, 0, 0);
    add_row(OP_RD, byte_addr(6'd20), 0, 0, 0);
    // user mode on channel 0, then a trigger count over four periods.
    add_row(OP_WR, byte_addr(timer_reg_pkg::T1LC), loads[0], 0, 0);
    add_row(OP_WR, byte_addr(timer_reg_pkg::T1CR), ctl_user, 0, 0);
    add_row(OP_WAIT, 0, 1, 1, loads[0] + 4);
    add_row(OP_TRIG, 0, 0, 4, 4 * (loads[0] + 1));
    add_row(OP_WR, byte_addr(timer_reg_pkg::T2LC), loads[1], 0, 0);
    add_row(OP_WR, byte_addr(timer_reg_pkg::T2CR), ctl_user, 0, 0);
    add_row(OP_WAIT, 0, 3, 3, loads[1] + 4);
    add_row(OP_RD, byte_addr(timer_reg_pkg::SRAW), 0, 3, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T1INTST), 0, 1, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T2INTST), 0, 1, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::SINTST), 0, 3, 0);
    // long reloads so that no expiry races the EOI reads.
    add_row(OP_WR, byte_addr(timer_reg_pkg::T1LC), 32'h0010_0000, 0, 0);
    add_row(OP_WR, byte_addr(timer_reg_pkg::T2LC), 32'h0010_0000, 0, 0);
    add_row(OP_IDLE, 0, 0, 0, 45);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T1EOI), 0, 0, 0);
    add_row(OP_WAIT, 0, 3, 2, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T1INTST), 0, 0, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T2INTST), 0, 1, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::SRAW), 0, 2, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::SEOI), 0, 0, 0);
    add_row(OP_WAIT, 0, 3, 0, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::SRAW), 0, 0, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T2INTST), 0, 0, 0);
    // masked channel 1 still shows up in the raw status.
    add_row(OP_WR, byte_addr(timer_reg_pkg::T2CR), 0, 0, 0);
    add_row(OP_WR, byte_addr(timer_reg_pkg::T2LC), loads[2], 0, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T2LC), 0, loads[2], 0);
    add_row(OP_WR, byte_addr(timer_reg_pkg::T2CR), ctl_mask, 0, 0);
    add_row(OP_IDLE, 0, 0, 0, loads[2] + 4);
    add_row(OP_RD, byte_addr(timer_reg_pkg::SRAW), 0, 2, 0);
    add_row(OP_WAIT, 0, 3, 0, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::SINTST), 0, 0, 0);
    add_row(OP_WR, byte_addr(timer_reg_pkg::T2CR), 0, 0, 0);
    // enable strobes on channel 0.
    add_row(OP_WR, byte_addr(timer_reg_pkg::T1LC), loads[3], 0, 0);
    add_row(OP_WR, byte_addr(timer_reg_pkg::T1CR), 0, 0, 0);
    add_row(OP_WR, byte_addr(timer_reg_pkg::T1CR), ctl_user, 0, 0);
    add_row(OP_WAIT, 0, 1, 1, loads[3] + 4);
    add_row(OP_STROBE, 0, 32'h4, 0, 0);
    add_row(OP_WAIT, 0, 3, 0, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T1CR), 0, ctl_user & ~ctl_free, 0);
    add_row(OP_STROBE, 0, 32'h1, 0, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T1CR), 0, ctl_user, 0);
    add_row(OP_WAIT, 0, 1, 1, loads[3] + 4);
    add_row(OP_WR_OFF, byte_addr(timer_reg_pkg::T1CR), ctl_user, 0, 0);
    add_row(OP_RD, byte_addr(timer_reg_pkg::T1CR), 0, ctl_user, 0);
    add_row(OP_WAIT, 0, 1, 1, 0);
    // free-running channel 1 wraps to all ones after its first expiry.
    add_row(OP_WR, byte_addr(timer_reg_pkg::T1CR), 0, 0, 0);
    add_row(OP_WR, byte_addr(timer_reg_pkg::T2LC), loads[4], 0, 0);
    add_row(OP_WR, byte_addr(timer_reg_pkg::T2CR), ctl_free, 0, 0);
    add_row(OP_WAIT, 0, 3, 2, loads[4] + 4);
    add_row(OP_RD_GT, byte_addr(timer_reg_pkg::T2CV), 0, loads[4], 0);
    add_row(OP_IDLE, 0, 0, 0, 10);
    add_row(OP_RD_GT, byte_addr(timer_reg_pkg::T2CV), 0, loads[4], 0);

    limit = 16 + 1000;
    foreach (rows[k])
      limit += rows[k].bound + 4;
    fork
      watchdog(limit);
    join_none

    wait (presetn === 1'b1);
    wait_cycles(1);
    compare_mask("o_intr", '0, o_intr);
    compare_mask("o_etb_trig", '0, o_etb_trig);
    foreach (rows[i])
    begin
      case (rows[i].op)
        OP_WR:     apb_write(rows[i].addr, rows[i].data, '0);
        OP_WR_OFF: apb_write(rows[i].addr, rows[i].data, '1);
        OP_RD:     read_check(rows[i].addr, rows[i].expv, 1'b0);
        OP_RD_GT:  read_check(rows[i].addr, rows[i].expv, 1'b1);
        OP_WAIT:   wait_intr(rows[i].data[1:0], rows[i].expv[1:0], rows[i].bound);
        OP_IDLE:   wait_cycles(rows[i].bound);
        OP_STROBE: pulse_strobe(rows[i].data[1:0], rows[i].data[3:2]);
        OP_TRIG:   count_trig(rows[i].addr[0], rows[i].bound, rows[i].expv);
      endcase
    end

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: tb.f
verilog/timer_reg_pkg.sv
verilog/timer_cfg_pkg.sv
verilog/timer_if.sv
verilog/timer_regs.sv
verilog/timer_counter.sv
verilog/timer_irq.sv
verilog/timer_top.sv
sim/tb_clock.sv
sim/timer_tb.sv

// File: verilog/timer_cfg_pkg.sv
//--------------------------------------------------------------------------
// Counter configuration: channel count, count width and their types.
//--------------------------------------------------------------------------
package timer_cfg_pkg;

  localparam int NUM_CH  = 2;
  localparam int COUNT_W = 32;

  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [NUM_CH-1:0]  ch_mask_t;  // one bit per channel.

endpackage

// File: verilog/timer_counter.sv
//--------------------------------------------------------------------------
// One down-counter channel with load on enable, reload at zero and a
// registered expiry flag.
//--------------------------------------------------------------------------
module timer_counter (
  input logic           pclk,
  input logic           presetn,
  timer_chan_if.counter chan
);

  timer_cfg_pkg::count_t count_q;
  logic                  en_q;
  logic                  expired_q;
  logic                  load;

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
      en_q <= 1'b0;
    else
      en_q <= chan.en;
  end

  assign load = chan.en && !en_q;  // rising edge of enable.

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
      count_q <= '1;
    else if (!chan.en)
      count_q <= '1;
    else if (load)
      count_q <= chan.load_value;
    else if (count_q == '0)
      count_q <= chan.mode ? chan.load_value : '1;  // user mode reloads, free mode wraps.
    else
      count_q <= count_q - timer_cfg_pkg::count_t'(1);
  end

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
      expired_q <= 1'b0;
    else
      expired_q <= (count_q == '0);
  end

  assign chan.expired = expired_q;
  assign chan.current = chan.en ? count_q : '0;

  // expiry is seen in the cycle where the count has just restarted after zero.
  a_expired_after_zero: assert property (@(posedge pclk) disable iff (!presetn)
    chan.expired |->
      count_q == (($past(chan.en) && $past(chan.mode)) ? $past(chan.load_value) : '1));

endmodule

// File: verilog/timer_if.sv
//--------------------------------------------------------------------------
// Interfaces of the timer block: per-channel counter link and the
// shared interrupt link, with their modports.
//--------------------------------------------------------------------------
interface timer_chan_if;

  logic                  en;
  logic                  mode;
  timer_cfg_pkg::count_t load_value;
  timer_cfg_pkg::count_t current;
  logic                  expired;  // high the cycle after the count hit zero.

  modport regs (
    output en,
    output mode,
    output load_value,
    input  current
  );

  modport counter (
    input  en,
    input  mode,
    input  load_value,
    output current,
    output expired
  );

  modport irq (
    input en,
    input expired
  );

endinterface

interface timer_irq_if;

  timer_cfg_pkg::ch_mask_t eoi;      // single-cycle clear strobes.
  logic                    eoi_all;
  timer_cfg_pkg::ch_mask_t mask;
  timer_cfg_pkg::ch_mask_t raw;
  timer_cfg_pkg::ch_mask_t status;

  modport regs (
    output eoi,
    output eoi_all,
    output mask,
    input  raw,
    input  status
  );

  modport irq (
    input  eoi,
    input  eoi_all,
    input  mask,
    output raw,
    output status
  );

endinterface

// File: verilog/timer_irq.sv
//--------------------------------------------------------------------------
// Expiry edge detection, pending bits with EOI clearing, masked status
// and the one-cycle event-trigger pulses.
//--------------------------------------------------------------------------
module timer_irq (
  input  logic                    pclk,
  input  logic                    presetn,
  timer_chan_if.irq               chan0,
  timer_chan_if.irq               chan1,
  timer_irq_if.irq                irq,
  output timer_cfg_pkg::ch_mask_t o_etb_trig
);

  timer_cfg_pkg::ch_mask_t en;
  timer_cfg_pkg::ch_mask_t expired;
  timer_cfg_pkg::ch_mask_t expired_d;
  timer_cfg_pkg::ch_mask_t rise;
  timer_cfg_pkg::ch_mask_t pending_q;
  timer_cfg_pkg::ch_mask_t trig_q;

  assign en      = {chan1.en, chan0.en};
  assign expired = {chan1.expired, chan0.expired};
  assign rise    = expired & ~expired_d;

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
    begin
      expired_d <= '0;
      trig_q    <= '0;
    end
    else
    begin
      expired_d <= expired;
      trig_q    <= rise;  // one pulse per expiry edge.
    end
  end

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
      pending_q <= '0;
    else
    begin
      for (int i = 0; i < timer_cfg_pkg::NUM_CH; i++)
      begin
        if (rise[i])
          pending_q[i] <= en[i];
        else if (irq.eoi[i] || irq.eoi_all || !en[i])
          pending_q[i] <= 1'b0;
      end
    end
  end

  assign irq.raw    = pending_q;
  assign irq.status = pending_q & ~irq.mask;
  assign o_etb_trig = trig_q;

  a_trig_one_cycle: assert property (@(posedge pclk) disable iff (!presetn)
    |trig_q |=> !(|(trig_q & $past(trig_q))));

  a_pending_off_when_disabled: assert property (@(posedge pclk) disable iff (!presetn)
    1'b1 |=> ((pending_q & ~$past(en)) == '0));

endmodule

// File: verilog/timer_reg_pkg.sv
//--------------------------------------------------------------------------
// Register map of the dual timer block: word offsets, control bit
// positions and the APB data, address and index types.
//--------------------------------------------------------------------------
package timer_reg_pkg;

  typedef logic [31:0] apb_data_t;
  typedef logic [7:0]  apb_addr_t;
  typedef logic [5:0]  reg_idx_t;  // word index, taken from paddr[7:2].

  localparam reg_idx_t T1LC    = 6'd0;
  localparam reg_idx_t T1CV    = 6'd1;
  localparam reg_idx_t T1CR    = 6'd2;
  localparam reg_idx_t T1EOI   = 6'd3;
  localparam reg_idx_t T1INTST = 6'd4;
  localparam reg_idx_t T2LC    = 6'd5;
  localparam reg_idx_t T2CV    = 6'd6;
  localparam reg_idx_t T2CR    = 6'd7;
  localparam reg_idx_t T2EOI   = 6'd8;
  localparam reg_idx_t T2INTST = 6'd9;
  localparam reg_idx_t SINTST  = 6'd40;
  localparam reg_idx_t SEOI    = 6'd41;
  localparam reg_idx_t SRAW    = 6'd42;

  localparam int CTRL_W    = 3;
  localparam int CTRL_EN   = 0;
  localparam int CTRL_MODE = 1;  // 1 selects user-reload mode.
  localparam int CTRL_MASK = 2;  // 1 masks the channel interrupt.

  typedef logic [CTRL_W-1:0] ctrl_t;

endpackage

// File: verilog/timer_regs.sv
//--------------------------------------------------------------------------
// APB register file: decode, load and control registers, EOI strobes
// and the registered read data mux.
//--------------------------------------------------------------------------
module timer_regs (
  input  logic                     pclk,
  input  logic                     presetn,
  input  logic                     i_psel,
  input  logic                     i_penable,
  input  logic                     i_pwrite,
  input  timer_reg_pkg::apb_addr_t i_paddr,
  input  timer_reg_pkg::apb_data_t i_pwdata,
  input  timer_cfg_pkg::ch_mask_t  i_trig_en_on,
  input  timer_cfg_pkg::ch_mask_t  i_trig_en_off,
  timer_chan_if.regs               chan0,
  timer_chan_if.regs               chan1,
  timer_irq_if.regs                irq,
  output timer_reg_pkg::apb_data_t o_prdata
);

  timer_reg_pkg::reg_idx_t  idx;
  logic                     wr_acc;
  logic                     rd_setup;
  timer_cfg_pkg::ch_mask_t  lc_wen;
  timer_cfg_pkg::ch_mask_t  cr_wen;
  timer_cfg_pkg::count_t    load_q [timer_cfg_pkg::NUM_CH];
  timer_reg_pkg::ctrl_t     ctrl_q [timer_cfg_pkg::NUM_CH];
  timer_reg_pkg::apb_data_t rd_data;

  assign idx      = i_paddr[7:2];
  assign wr_acc   = i_psel && i_penable && i_pwrite;
  assign rd_setup = i_psel && !i_penable && !i_pwrite;  // reads act in the setup phase.

  assign lc_wen[0] = wr_acc && (idx == timer_reg_pkg::T1LC);
  assign lc_wen[1] = wr_acc && (idx == timer_reg_pkg::T2LC);
  assign cr_wen[0] = wr_acc && (idx == timer_reg_pkg::T1CR);
  assign cr_wen[1] = wr_acc && (idx == timer_reg_pkg::T2CR);

  assign irq.eoi[0]  = rd_setup && (idx == timer_reg_pkg::T1EOI);
  assign irq.eoi[1]  = rd_setup && (idx == timer_reg_pkg::T2EOI);
  assign irq.eoi_all = rd_setup && (idx == timer_reg_pkg::SEOI);

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
    begin
      for (int i = 0; i < timer_cfg_pkg::NUM_CH; i++)
      begin
        load_q[i] <= '0;
        ctrl_q[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < timer_cfg_pkg::NUM_CH; i++)
      begin
        if (lc_wen[i])
          load_q[i] <= i_pwdata[timer_cfg_pkg::COUNT_W-1:0];
        if (cr_wen[i])
          ctrl_q[i] <= i_pwdata[timer_reg_pkg::CTRL_W-1:0];  // bus write beats both strobes.
        else if (i_trig_en_off[i])
          ctrl_q[i][timer_reg_pkg::CTRL_EN] <= 1'b0;
        else if (i_trig_en_on[i])
          ctrl_q[i][timer_reg_pkg::CTRL_EN] <= 1'b1;
      end
    end
  end

  assign chan0.en         = ctrl_q[0][timer_reg_pkg::CTRL_EN];
  assign chan0.mode       = ctrl_q[0][timer_reg_pkg::CTRL_MODE];
  assign chan0.load_value = load_q[0];
  assign chan1.en         = ctrl_q[1][timer_reg_pkg::CTRL_EN];
  assign chan1.mode       = ctrl_q[1][timer_reg_pkg::CTRL_MODE];
  assign chan1.load_value = load_q[1];
  assign irq.mask[0]      = ctrl_q[0][timer_reg_pkg::CTRL_MASK];
  assign irq.mask[1]      = ctrl_q[1][timer_reg_pkg::CTRL_MASK];

  always_comb
  begin
    case (idx)
      timer_reg_pkg::T1LC:    rd_data = timer_reg_pkg::apb_data_t'(load_q[0]);
      timer_reg_pkg::T1CV:    rd_data = timer_reg_pkg::apb_data_t'(chan0.current);
      timer_reg_pkg::T1CR:    rd_data = timer_reg_pkg::apb_data_t'(ctrl_q[0]);
      timer_reg_pkg::T1INTST: rd_data = timer_reg_pkg::apb_data_t'(irq.status[0]);
      timer_reg_pkg::T2LC:    rd_data = timer_reg_pkg::apb_data_t'(load_q[1]);
      timer_reg_pkg::T2CV:    rd_data = timer_reg_pkg::apb_data_t'(chan1.current);
      timer_reg_pkg::T2CR:    rd_data = timer_reg_pkg::apb_data_t'(ctrl_q[1]);
      timer_reg_pkg::T2INTST: rd_data = timer_reg_pkg::apb_data_t'(irq.status[1]);
      timer_reg_pkg::SINTST:  rd_data = timer_reg_pkg::apb_data_t'(irq.status);
      timer_reg_pkg::SRAW:    rd_data = timer_reg_pkg::apb_data_t'(irq.raw);
      default:                rd_data = '0;
    endcase
  end

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
      o_prdata <= '0;
    else if (rd_setup)
      o_prdata <= rd_data;  // held stable through the access phase.
  end

  // the transfer that fires an EOI strobe never completes as a write.
  a_eoi_not_on_write: assert property (@(posedge pclk) disable iff (!presetn)
    (|irq.eoi || irq.eoi_all) |=> !wr_acc);

endmodule

// File: verilog/timer_top.sv
//--------------------------------------------------------------------------
// Top level of the dual APB timer: register file, two counters and
// the interrupt block, joined by interfaces.
//--------------------------------------------------------------------------
module timer_top (
  input  logic                     pclk,
  input  logic                     presetn,
  input  logic                     i_psel,
  input  logic                     i_penable,
  input  logic                     i_pwrite,
  input  timer_reg_pkg::apb_addr_t i_paddr,
  input  timer_reg_pkg::apb_data_t i_pwdata,
  input  timer_cfg_pkg::ch_mask_t  i_etb_trig_en_on,
  input  timer_cfg_pkg::ch_mask_t  i_etb_trig_en_off,
  output timer_reg_pkg::apb_data_t o_prdata,
  output timer_cfg_pkg::ch_mask_t  o_intr,
  output timer_cfg_pkg::ch_mask_t  o_etb_trig
);

  timer_chan_if chan0_if ();
  timer_chan_if chan1_if ();
  timer_irq_if  irq_if ();

  timer_regs u_regs (
    .pclk          (pclk),
    .presetn       (presetn),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_pwrite      (i_pwrite),
    .i_paddr       (i_paddr),
    .i_pwdata      (i_pwdata),
    .i_trig_en_on  (i_etb_trig_en_on),
    .i_trig_en_off (i_etb_trig_en_off),
    .chan0         (chan0_if.regs),
    .chan1         (chan1_if.regs),
    .irq           (irq_if.regs),
    .o_prdata      (o_prdata)
  );

  timer_counter u_counter0 (
    .pclk    (pclk),
    .presetn (presetn),
    .chan    (chan0_if.counter)
  );

  timer_counter u_counter1 (
    .pclk    (pclk),
    .presetn (presetn),
    .chan    (chan1_if.counter)
  );

  timer_irq u_irq (
    .pclk       (pclk),
    .presetn    (presetn),
    .chan0      (chan0_if.irq),
    .chan1      (chan1_if.irq),
    .irq        (irq_if.irq),
    .o_etb_trig (o_etb_trig)
  );

  assign o_intr = irq_if.status;  // masked status drives the interrupt lines.

endmodule
